//--- source/csr_pkg.sv
package csr_pkg;

    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    // machine-mode register addresses
    localparam logic [csr_addr_w-1:0] addr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_mie      = 12'h304;
    localparam logic [csr_addr_w-1:0] addr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] addr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause   = 12'h342;
    localparam logic [csr_addr_w-1:0] addr_mtval    = 12'h343;
    localparam logic [csr_addr_w-1:0] addr_mip      = 12'h344;
    localparam logic [csr_addr_w-1:0] addr_mhartid  = 12'hf14;

    // writable bits per register
    localparam logic [xlen-1:0] mstatus_mask = 32'h0000_1888;
    localparam logic [xlen-1:0] mie_mask     = 32'h0000_0888;
    localparam logic [xlen-1:0] mtvec_mask   = 32'hffff_fffc;
    localparam logic [xlen-1:0] mepc_mask    = 32'hffff_fffc;

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_m = 2'd3
    } priv_t;

    typedef enum logic [1:0] {
        op_rw = 2'd1,
        op_rs = 2'd2,
        op_rc = 2'd3
    } csr_op_t;

    // reserved fields read as zero
    typedef struct packed {
        logic [18:0] rsvd_hi;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_mid;
        logic        mpie;
        logic [2:0]  rsvd_lo;
        logic        mie;
        logic [2:0]  rsvd_base;
    } mstatus_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        mstatus_t        fld;
    } mstatus_u;

endpackage

//--- source/trap_pkg.sv
package trap_pkg;

    import csr_pkg::*;

    localparam int exc_code_w = 5;

    localparam logic [exc_code_w-1:0] exc_illegal    = 5'd2;
    localparam logic [exc_code_w-1:0] exc_breakpoint = 5'd3;
    localparam logic [exc_code_w-1:0] exc_ecall_u    = 5'd8;
    localparam logic [exc_code_w-1:0] exc_ecall_m    = 5'd11;

    // interrupt codes double as mip/mie bit positions
    localparam logic [exc_code_w-1:0] irq_msi = 5'd3;
    localparam logic [exc_code_w-1:0] irq_mti = 5'd7;
    localparam logic [exc_code_w-1:0] irq_mei = 5'd11;

    typedef enum logic [1:0] {
        kind_exc  = 2'd0,
        kind_irq  = 2'd1,
        kind_mret = 2'd2
    } trap_kind_t;

    typedef struct packed {
        logic                  valid;
        csr_op_t               op;
        logic                  use_imm;
        logic [csr_addr_w-1:0] addr;
        logic [xlen-1:0]       src;
        logic [xlen-1:0]       imm;
    } csr_req_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [xlen-1:0] rdata;
    } csr_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [csr_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        logic                  valid;
        trap_kind_t            kind;
        logic [exc_code_w-1:0] code;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       tval;
    } trap_req_t;

    typedef struct packed {
        logic            valid;
        logic            save_ctx;
        mstatus_u        mstatus;
        priv_t           mode;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] cause;
        logic [xlen-1:0] tval;
    } trap_upd_t;

    typedef struct packed {
        logic                  pending;
        logic [exc_code_w-1:0] code;
    } irq_info_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } redirect_t;

endpackage

//--- source/csr_access.sv
`timescale 1ns/100ps

module csr_access
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  csr_req_t              req,
    output logic [csr_addr_w-1:0] rd_addr,
    input  logic [xlen-1:0]       rd_data,
    input  logic                  rd_hit,
    input  priv_t                 mode,
    output csr_wr_t               wr,
    output csr_resp_t             resp
);

    logic [xlen-1:0] operand;
    logic [xlen-1:0] new_val;
    logic            does_write;
    logic            priv_fail;
    logic            ro_fail;
    logic            illegal;

    assign rd_addr = req.addr;

    assign operand = req.use_imm ? req.imm : req.src;

    // set/clear with zero source is a pure read
    assign does_write = (req.op == op_rw) || (operand != '0);

    always_comb begin
        case (req.op)
            op_rs:   new_val = rd_data | operand;
            op_rc:   new_val = rd_data & ~operand;
            default: new_val = operand;
        endcase
    end

    assign priv_fail = req.addr[9:8] > mode;
    assign ro_fail   = does_write && (req.addr[11:10] == 2'b11);
    assign illegal   = !rd_hit || priv_fail || ro_fail;

    assign wr.valid = req.valid && !illegal && does_write;
    assign wr.addr  = req.addr;
    assign wr.data  = new_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp <= '0;
        end else begin
            resp.valid   <= req.valid;
            resp.illegal <= illegal;
            // old value or zero on a refused access
            resp.rdata   <= illegal ? '0 : rd_data;
        end
    end

endmodule

//--- source/csr_file.sv
`timescale 1ns/100ps

module csr_file
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [csr_addr_w-1:0] rd_addr,
    output logic [xlen-1:0]       rd_data,
    output logic                  rd_hit,
    input  csr_wr_t               wr,
    input  trap_upd_t             upd,
    input  logic [xlen-1:0]       mip,
    output priv_t                 mode,
    output mstatus_u              mstatus,
    output logic [xlen-1:0]       mie,
    output logic [xlen-1:0]       mtvec,
    output logic [xlen-1:0]       mepc
);

    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode        <= priv_m;
            mstatus.raw <= '0;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
        end else begin
            if (wr.valid) begin
                // mip and mhartid writes fall through
                case (wr.addr)
                    addr_mstatus:  mstatus.raw <= wr.data & mstatus_mask;
                    addr_mie:      mie <= wr.data & mie_mask;
                    addr_mtvec:    mtvec <= wr.data & mtvec_mask;
                    addr_mscratch: mscratch <= wr.data;
                    addr_mepc:     mepc <= wr.data & mepc_mask;
                    addr_mcause:   mcause <= wr.data;
                    addr_mtval:    mtval <= wr.data;
                    default: ;
                endcase
            end
            // trap side wins over a same-cycle CSR write
            if (upd.valid) begin
                mode        <= upd.mode;
                mstatus.raw <= upd.mstatus.raw & mstatus_mask;
                if (upd.save_ctx) begin
                    mepc   <= upd.epc & mepc_mask;
                    mcause <= upd.cause;
                    mtval  <= upd.tval;
                end
            end
        end
    end

    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (rd_addr)
            addr_mstatus:  rd_data = mstatus.raw;
            addr_mie:      rd_data = mie;
            addr_mtvec:    rd_data = mtvec;
            addr_mscratch: rd_data = mscratch;
            addr_mepc:     rd_data = mepc;
            addr_mcause:   rd_data = mcause;
            addr_mtval:    rd_data = mtval;
            addr_mip:      rd_data = mip;
            // single hart
            addr_mhartid:  rd_data = '0;
            default:       rd_hit = 1'b0;
        endcase
    end

endmodule

//--- source/trap_unit.sv
`timescale 1ns/100ps

module trap_unit
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  trap_req_t       req,
    input  irq_info_t       irq_info,
    input  priv_t           mode,
    input  mstatus_u        mstatus,
    input  logic [xlen-1:0] mtvec,
    input  logic [xlen-1:0] mepc,
    output trap_upd_t       upd,
    output redirect_t       redirect
);

    logic                  mret_ok;
    logic                  is_ecall;
    logic [exc_code_w-1:0] exc_code;
    mstatus_u              next_status;
    priv_t                 ret_mode;

    assign mret_ok  = (req.kind == kind_mret) && (mode == priv_m);
    assign is_ecall = (req.code == exc_ecall_u) || (req.code == exc_ecall_m);

    always_comb begin
        if (req.kind == kind_mret) begin
            exc_code = exc_illegal;
        end else if (is_ecall) begin
            exc_code = (mode == priv_u) ? exc_ecall_u : exc_ecall_m;
        end else begin
            exc_code = req.code;
        end
    end

    // unsupported mpp values return to user mode
    assign ret_mode = (mstatus.fld.mpp == priv_m) ? priv_m : priv_u;

    always_comb begin
        next_status = mstatus;
        if (mret_ok) begin
            next_status.fld.mie  = mstatus.fld.mpie;
            next_status.fld.mpie = 1'b1;
            next_status.fld.mpp  = priv_u;
        end else begin
            next_status.fld.mpie = mstatus.fld.mie;
            next_status.fld.mie  = 1'b0;
            next_status.fld.mpp  = mode;
        end
    end

    always_comb begin
        upd.valid    = req.valid;
        upd.save_ctx = !mret_ok;
        upd.mstatus  = next_status;
        upd.mode     = mret_ok ? ret_mode : priv_m;
        upd.epc      = req.pc;
        if (req.kind == kind_irq) begin
            upd.cause = {1'b1, {(xlen-1-exc_code_w){1'b0}}, irq_info.code};
            upd.tval  = '0;
        end else begin
            upd.cause = {{(xlen-exc_code_w){1'b0}}, exc_code};
            upd.tval  = (req.kind == kind_exc) ? req.tval : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect <= '0;
        end else begin
            redirect.valid <= req.valid;
            redirect.pc    <= mret_ok ? mepc : (mtvec & mtvec_mask);
        end
    end

endmodule

//--- source/irq_unit.sv
`timescale 1ns/100ps

module irq_unit
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            msip,
    input  logic            mtip,
    input  logic            meip,
    input  logic [xlen-1:0] mie,
    input  mstatus_u        mstatus,
    input  priv_t           mode,
    output logic [xlen-1:0] mip,
    output irq_info_t       irq_info
);

    // {meip, mtip, msip}
    logic [2:0]      sync_q1;
    logic [2:0]      sync_q2;
    logic [xlen-1:0] enabled;
    logic            global_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= {meip, mtip, msip};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        mip          = '0;
        mip[irq_msi] = sync_q2[0];
        mip[irq_mti] = sync_q2[1];
        mip[irq_mei] = sync_q2[2];
    end

    assign enabled   = mip & mie;
    assign global_en = (mode == priv_u) || mstatus.fld.mie;

    assign irq_info.pending = (|enabled) && global_en;

    // external beats timer beats software
    always_comb begin
        if (enabled[irq_mei]) begin
            irq_info.code = irq_mei;
        end else if (enabled[irq_mti]) begin
            irq_info.code = irq_mti;
        end else if (enabled[irq_msi]) begin
            irq_info.code = irq_msi;
        end else begin
            irq_info.code = '0;
        end
    end

endmodule

//--- source/csr_top.sv
`timescale 1ns/100ps

module csr_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  csr_req_t  csr_req,
    input  trap_req_t trap_req,
    input  logic      msip,
    input  logic      mtip,
    input  logic      meip,
    output csr_resp_t csr_resp,
    output redirect_t redirect,
    output irq_info_t irq_info
);

    logic [csr_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rd_data;
    logic                  rd_hit;
    priv_t                 mode;
    mstatus_u              mstatus;
    logic [xlen-1:0]       mie;
    logic [xlen-1:0]       mtvec;
    logic [xlen-1:0]       mepc;
    logic [xlen-1:0]       mip;
    csr_wr_t               wr;
    trap_upd_t             upd;

    csr_access u_access (
        .clk     (clk),
        .rst     (rst),
        .req     (csr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_hit  (rd_hit),
        .mode    (mode),
        .wr      (wr),
        .resp    (csr_resp)
    );

    csr_file u_file (
        .clk     (clk),
        .rst     (rst),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_hit  (rd_hit),
        .wr      (wr),
        .upd     (upd),
        .mip     (mip),
        .mode    (mode),
        .mstatus (mstatus),
        .mie     (mie),
        .mtvec   (mtvec),
        .mepc    (mepc)
    );

    trap_unit u_trap (
        .clk      (clk),
        .rst      (rst),
        .req      (trap_req),
        .irq_info (irq_info),
        .mode     (mode),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .upd      (upd),
        .redirect (redirect)
    );

    irq_unit u_irq (
        .clk      (clk),
        .rst      (rst),
        .msip     (msip),
        .mtip     (mtip),
        .meip     (meip),
        .mie      (mie),
        .mstatus  (mstatus),
        .mode     (mode),
        .mip      (mip),
        .irq_info (irq_info)
    );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
    end

    // 8 ns period
    always #4 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb/csr_checker.sv
`timescale 1ns/100ps

module csr_checker
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  csr_resp_t csr_resp,
    input  redirect_t redirect,
    input  irq_info_t irq_info,
    input  logic      exp_resp_valid,
    input  csr_resp_t exp_resp,
    input  logic      exp_redir_valid,
    input  redirect_t exp_redir,
    input  logic      exp_irq_chk,
    input  irq_info_t exp_irq,
    input  int        test_id,
    input  logic      test_done,
    output int        errors,
    output int        tests
);

    // error count when the current test started
    int test_base;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_values";
            2: return "random_csr";
            3: return "illegal_access";
            4: return "exception_mret";
            5: return "mret_user";
            6: return "interrupts";
            default: return "none";
        endcase
    endfunction

    // sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            errors    = 0;
            tests     = 0;
            test_base = 0;
        end else begin
            if (exp_resp_valid) begin
                if (!csr_resp.valid) begin
                    $display("test %s: a CSR response was expected but none came",
                             test_name(test_id));
                    errors = errors + 1;
                end else if ({csr_resp.illegal, csr_resp.rdata} !=
                             {exp_resp.illegal, exp_resp.rdata}) begin
                    $display("FAILED %s: csr response expected %h actual %h",
                             test_name(test_id), {exp_resp.illegal, exp_resp.rdata},
                             {csr_resp.illegal, csr_resp.rdata});
                    errors = errors + 1;
                end
            end else if (csr_resp.valid) begin
                $display("test %s: a CSR response came that was not expected",
                         test_name(test_id));
                errors = errors + 1;
            end

            if (exp_redir_valid) begin
                if (!redirect.valid) begin
                    $display("test %s: a redirect was expected but none came",
                             test_name(test_id));
                    errors = errors + 1;
                end else if (redirect.pc != exp_redir.pc) begin
                    $display("FAILED %s: redirect pc expected %h actual %h",
                             test_name(test_id), exp_redir.pc, redirect.pc);
                    errors = errors + 1;
                end
            end else if (redirect.valid) begin
                $display("test %s: a redirect came that was not expected",
                         test_name(test_id));
                errors = errors + 1;
            end

            if (exp_irq_chk && (irq_info != exp_irq)) begin
                $display("FAILED %s: irq_info expected %h actual %h",
                         test_name(test_id), exp_irq, irq_info);
                errors = errors + 1;
            end

            if (test_done) begin
                $display("test %s finished with %0d errors", test_name(test_id),
                         errors - test_base);
                tests     = tests + 1;
                test_base = errors;
            end
        end
    end

endmodule

//--- tb/csr_tb.sv
`timescale 1ns/100ps

module csr_tb
    import csr_pkg::*;
    import trap_pkg::*;
();

    // requests and line changes over all six tests
    localparam int total_ops = 9 + 200 + 15 + 9 + 5 + 20 * 7;
    localparam int margin    = 4;

    localparam logic [11:0] all_addrs [9] = '{
        addr_mstatus, addr_mie, addr_mtvec, addr_mscratch, addr_mepc,
        addr_mcause, addr_mtval, addr_mip, addr_mhartid
    };

    logic      clk;
    logic      rst;
    csr_req_t  csr_req;
    trap_req_t trap_req;
    logic      msip;
    logic      mtip;
    logic      meip;
    csr_resp_t csr_resp;
    redirect_t redirect;
    irq_info_t irq_info;

    logic      exp_resp_valid;
    csr_resp_t exp_resp;
    logic      exp_redir_valid;
    redirect_t exp_redir;
    logic      exp_irq_chk;
    irq_info_t exp_irq;
    int        test_id;
    logic      test_done;
    int        errors;
    int        tests;

    logic [31:0] lcg_state;

    // model copies of the architectural state
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [31:0] m_mip;
    logic [1:0]  m_mode;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    csr_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .csr_req  (csr_req),
        .trap_req (trap_req),
        .msip     (msip),
        .mtip     (mtip),
        .meip     (meip),
        .csr_resp (csr_resp),
        .redirect (redirect),
        .irq_info (irq_info)
    );

    csr_checker u_chk (
        .clk             (clk),
        .rst             (rst),
        .csr_resp        (csr_resp),
        .redirect        (redirect),
        .irq_info        (irq_info),
        .exp_resp_valid  (exp_resp_valid),
        .exp_resp        (exp_resp),
        .exp_redir_valid (exp_redir_valid),
        .exp_redir       (exp_redir),
        .exp_irq_chk     (exp_irq_chk),
        .exp_irq         (exp_irq),
        .test_id         (test_id),
        .test_done       (test_done),
        .errors          (errors),
        .tests           (tests)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // returns {illegal, old value} and applies the write to the model
    function automatic logic [32:0] ref_csr(input csr_op_t op, input logic [11:0] addr,
                                            input logic [31:0] operand);
        logic [31:0] old;
        logic [31:0] nv;
        logic        hit;
        logic        writes;
        hit = 1'b1;
        old = '0;
        case (addr)
            addr_mstatus:  old = m_mstatus;
            addr_mie:      old = m_mie;
            addr_mtvec:    old = m_mtvec;
            addr_mscratch: old = m_mscratch;
            addr_mepc:     old = m_mepc;
            addr_mcause:   old = m_mcause;
            addr_mtval:    old = m_mtval;
            addr_mip:      old = m_mip;
            addr_mhartid:  old = '0;
            default:       hit = 1'b0;
        endcase
        writes = (op == op_rw) || (operand != '0);
        if (!hit || (addr[9:8] > m_mode) || (writes && (addr[11:10] == 2'b11))) begin
            return {1'b1, 32'h0};
        end
        if (op == op_rw) begin
            nv = operand;
        end else if (op == op_rs) begin
            nv = old | operand;
        end else begin
            nv = old & ~operand;
        end
        if (writes) begin
            case (addr)
                addr_mstatus:  m_mstatus = nv & mstatus_mask;
                addr_mie:      m_mie = nv & mie_mask;
                addr_mtvec:    m_mtvec = nv & mtvec_mask;
                addr_mscratch: m_mscratch = nv;
                addr_mepc:     m_mepc = nv & mepc_mask;
                addr_mcause:   m_mcause = nv;
                addr_mtval:    m_mtval = nv;
                default: ;
            endcase
        end
        return {1'b0, old};
    endfunction

    function automatic logic [5:0] ref_irq();
        logic [31:0] en;
        logic        pend;
        logic [4:0]  code;
        en   = m_mip & m_mie;
        pend = (|en) && ((m_mode == 2'd0) || m_mstatus[3]);
        if (en[11]) begin
            code = 5'd11;
        end else if (en[7]) begin
            code = 5'd7;
        end else if (en[3]) begin
            code = 5'd3;
        end else begin
            code = 5'd0;
        end
        return {pend, code};
    endfunction

    // returns the redirect target
    function automatic logic [31:0] ref_trap(input trap_kind_t kind, input logic [4:0] code,
                                             input logic [31:0] pc, input logic [31:0] tval);
        logic [31:0] cause;
        logic [31:0] target;
        logic [31:0] tv;
        logic [1:0]  ret_mode;
        logic [5:0]  irq;
        if ((kind == kind_mret) && (m_mode == 2'd3)) begin
            target       = m_mepc;
            ret_mode     = (m_mstatus[12:11] == 2'd3) ? 2'd3 : 2'd0;
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
            m_mstatus[12:11] = 2'd0;
            m_mode       = ret_mode;
            return target;
        end
        irq = ref_irq();
        tv  = 32'h0;
        if (kind == kind_mret) begin
            cause = {27'b0, exc_illegal};
        end else if (kind == kind_irq) begin
            cause = {1'b1, 26'b0, irq[4:0]};
        end else begin
            tv = tval;
            if ((code == exc_ecall_u) || (code == exc_ecall_m)) begin
                cause = (m_mode == 2'd0) ? 32'd8 : 32'd11;
            end else begin
                cause = {27'b0, code};
            end
        end
        m_mstatus[7]     = m_mstatus[3];
        m_mstatus[3]     = 1'b0;
        m_mstatus[12:11] = m_mode;
        m_mode           = 2'd3;
        m_mepc           = pc & 32'hffff_fffc;
        m_mcause         = cause;
        m_mtval          = tv;
        return m_mtvec & 32'hffff_fffc;
    endfunction

    task automatic issue_csr(input csr_op_t op, input logic use_imm, input logic [11:0] addr,
                             input logic [31:0] val);
        csr_req_t    req;
        logic [32:0] res;
        req.valid   = 1'b1;
        req.op      = op;
        req.use_imm = use_imm;
        req.addr    = addr;
        req.src     = use_imm ? lcg_next() : val;
        req.imm     = use_imm ? val : lcg_next();
        res = ref_csr(op, addr, val);
        @(posedge clk);
        csr_req         <= req;
        exp_resp_valid  <= 1'b0;
        exp_redir_valid <= 1'b0;
        @(posedge clk);
        req.valid      = 1'b0;
        csr_req        <= req;
        exp_resp_valid <= 1'b1;
        exp_resp       <= {1'b1, res};
    endtask

    task automatic issue_trap(input trap_kind_t kind, input logic [4:0] code,
                              input logic [31:0] pc, input logic [31:0] tval);
        trap_req_t   req;
        logic [31:0] target;
        req.valid = 1'b1;
        req.kind  = kind;
        req.code  = code;
        req.pc    = pc;
        req.tval  = tval;
        target = ref_trap(kind, code, pc, tval);
        @(posedge clk);
        trap_req        <= req;
        exp_resp_valid  <= 1'b0;
        exp_redir_valid <= 1'b0;
        @(posedge clk);
        req.valid       = 1'b0;
        trap_req        <= req;
        exp_redir_valid <= 1'b1;
        exp_redir       <= {1'b1, target};
    endtask

    // old irq_info for two edges, new one after the second
    task automatic set_lines(input logic [2:0] lines);
        @(posedge clk);
        {meip, mtip, msip} <= lines;
        exp_resp_valid  <= 1'b0;
        exp_redir_valid <= 1'b0;
        exp_irq_chk     <= 1'b1;
        exp_irq         <= ref_irq();
        @(posedge clk);
        @(posedge clk);
        m_mip = {20'b0, lines[2], 3'b0, lines[1], 3'b0, lines[0], 3'b0};
        exp_irq <= ref_irq();
        @(posedge clk);
        exp_irq_chk <= 1'b0;
    endtask

    task automatic begin_test(input int id);
        @(posedge clk);
        test_id         <= id;
        exp_resp_valid  <= 1'b0;
        exp_redir_valid <= 1'b0;
    endtask

    task automatic end_test();
        @(posedge clk);
        exp_resp_valid  <= 1'b0;
        exp_redir_valid <= 1'b0;
        exp_irq_chk     <= 1'b0;
        test_done       <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin
        #(total_ops * 8 * margin);
        $display("timeout: the tests did not finish in the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] val;
        logic [5:0]  irq;
        csr_op_t     op;
        int          k;
        csr_req         <= '0;
        trap_req        <= '0;
        msip            <= 1'b0;
        mtip            <= 1'b0;
        meip            <= 1'b0;
        exp_resp_valid  <= 1'b0;
        exp_resp        <= '0;
        exp_redir_valid <= 1'b0;
        exp_redir       <= '0;
        exp_irq_chk     <= 1'b0;
        exp_irq         <= '0;
        test_id         <= 0;
        test_done       <= 1'b0;
        lcg_state  = 32'd17527;
        m_mstatus  = '0;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        m_mip      = '0;
        m_mode     = 2'd3;
        @(negedge rst);

        begin_test(1);
        exp_irq_chk <= 1'b1;
        exp_irq     <= '0;
        for (int i = 0; i < 9; i++) begin
            issue_csr(op_rs, 1'b0, all_addrs[i], 32'h0);
        end
        end_test();

        begin_test(2);
        repeat (200) begin
            r = lcg_next();
            k = int'(r[3:0]) % 3;
            op = (k == 0) ? op_rw : ((k == 1) ? op_rs : op_rc);
            k = int'(r[15:8]) % 7;
            val = lcg_next();
            if (r[4]) begin
                val = {27'b0, val[4:0]};
            end
            if (r[7:5] == 3'd0) begin
                val = '0;
            end
            issue_csr(op, r[4], all_addrs[k], val);
        end
        end_test();

        begin_test(3);
        issue_csr(op_rw, 1'b0, 12'h7c0, lcg_next());
        issue_csr(op_rs, 1'b0, addr_mhartid, 32'h1);
        issue_csr(op_rw, 1'b0, addr_mhartid, lcg_next());
        issue_csr(op_rs, 1'b0, addr_mhartid, 32'h0);
        issue_csr(op_rw, 1'b0, addr_mscratch, 32'h5a5a_1234);
        issue_csr(op_rc, 1'b0, addr_mstatus, 32'h0000_1800);
        issue_csr(op_rw, 1'b0, addr_mepc, 32'h0000_2000);
        issue_trap(kind_mret, 5'd0, lcg_next(), 32'h0);
        issue_csr(op_rs, 1'b0, addr_mscratch, 32'h0);
        issue_csr(op_rw, 1'b0, addr_mscratch, lcg_next());
        issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0);
        // ecall from user mode brings machine mode back
        issue_trap(kind_exc, exc_ecall_m, 32'h0000_2000, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mscratch, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mcause, 32'h0);
        end_test();

        begin_test(4);
        issue_csr(op_rw, 1'b0, addr_mtvec, lcg_next() | 32'h3);
        issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0000_0008);
        issue_trap(kind_exc, exc_breakpoint, lcg_next(), lcg_next());
        issue_csr(op_rs, 1'b0, addr_mepc, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mcause, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mtval, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0);
        issue_trap(kind_mret, 5'd0, lcg_next(), 32'h0);
        issue_csr(op_rs, 1'b0, addr_mscratch, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0);
        end_test();

        begin_test(5);
        issue_csr(op_rc, 1'b0, addr_mstatus, 32'h0000_1800);
        issue_trap(kind_mret, 5'd0, lcg_next(), 32'h0);
        issue_trap(kind_mret, 5'd0, lcg_next(), 32'h0);
        issue_csr(op_rs, 1'b0, addr_mcause, 32'h0);
        issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0);
        end_test();

        begin_test(6);
        repeat (20) begin
            r = lcg_next();
            issue_csr(op_rw, 1'b0, addr_mie, lcg_next());
            issue_csr(r[0] ? op_rs : op_rc, 1'b0, addr_mstatus, 32'h0000_0008);
            set_lines(r[3:1]);
            irq = ref_irq();
            if (irq[5]) begin
                issue_trap(kind_irq, 5'd0, lcg_next(), lcg_next());
                issue_csr(op_rs, 1'b0, addr_mcause, 32'h0);
                issue_csr(op_rs, 1'b0, addr_mstatus, 32'h0);
            end
        end
        end_test();

        @(negedge clk);
        @(negedge clk);
        $display("%0d tests run, %0d errors", tests, errors);
        if ((errors == 0) && (tests == 6)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
source/csr_pkg.sv
source/trap_pkg.sv
source/csr_access.sv
source/csr_file.sv
source/trap_unit.sv
source/irq_unit.sv
source/csr_top.sv
tb/tb_clock.sv
tb/csr_checker.sv
tb/csr_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module csr_tb -Mdir obj_dir -o csr_sim
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
